/* design/tx_frame_pkg.sv */
package tx_frame_pkg;

    // Widths used across the framer.
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] crc_t;
    typedef logic [6:0]  count_t;    // Reaches at most SHR_LAST.
    typedef logic [2:0]  bit_idx_t;
    typedef logic [5:0]  buf_ptr_t;

    typedef enum logic [1:0] {
        WAITING  = 2'd0,
        SHR      = 2'd1,
        PHR_PSDU = 2'd2,
        FCS      = 2'd3
    } frame_state_e;

    // Reflected CCITT CRC with no final inversion.
    localparam crc_t CRC_INIT      = 16'hffff;
    localparam crc_t CRC_POLY_REFL = 16'h8408;

    // Synchronisation header bytes.
    localparam byte_t PREAMBLE_BYTE = 8'haa;
    localparam byte_t SFD_BYTE0     = 8'hf3;
    localparam byte_t SFD_BYTE1     = 8'h98;

    // Terminal counts per state.
    localparam count_t PREAMBLE_CYCLES = 7'd64;
    localparam count_t SHR_LAST        = 7'd79;
    localparam count_t BYTE_LAST       = 7'd7;
    localparam count_t FCS_LAST        = 7'd15;

    localparam int BUF_DEPTH = 64;

endpackage

/* design/frame_timing_if.sv */
`timescale 1ns/1ps

interface frame_timing_if import tx_frame_pkg::*; ();

    frame_state_e state;
    count_t       count;
    bit_idx_t     bit_idx;
    logic         count_last;   // Counter is at its terminal value.
    logic         pop;          // Advance the payload FIFO.
    logic         last_byte;    // One entry left in the FIFO.

    modport ctrl_mp    (output state, output pop, input count_last, input last_byte);

    modport counter_mp (input state, output count, output bit_idx, output count_last);

    modport buffer_mp  (input pop, output last_byte);

    modport data_mp    (input state, input count, input bit_idx);

endinterface

/* design/frame_ctrl_fsm.sv */
`timescale 1ns/1ps

module frame_ctrl_fsm import tx_frame_pkg::*; (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            start,
    frame_timing_if.ctrl_mp tmg,
    input  logic            buffer_empty,
    output logic            busy,
    output logic            frame_done
);

    frame_state_e state;
    frame_state_e next_state;

    always_comb begin
        next_state = state;
        case (state)
            WAITING: begin
                if (start && !buffer_empty)
                    next_state = SHR;
            end
            SHR: begin
                if (tmg.count_last)
                    next_state = PHR_PSDU;
            end
            PHR_PSDU: begin
                // Leave once the final buffered byte has gone out.
                if (tmg.count_last && tmg.last_byte)
                    next_state = FCS;
            end
            FCS: begin
                if (tmg.count_last)
                    next_state = WAITING;
            end
            default: next_state = WAITING;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            state <= WAITING;
        else
            state <= next_state;
    end

    assign tmg.state  = state;
    assign tmg.pop    = (state == PHR_PSDU) && tmg.count_last;  // One pop per byte.
    assign busy       = (state != WAITING);
    assign frame_done = (state == FCS) && tmg.count_last;

    a_state_known: assert property (@(posedge clk) disable iff (!reset_n)
        !$isunknown(state))
        else $error("frame_ctrl_fsm: state is unknown");

    // The FIFO holds data for as long as payload bytes go out.
    a_payload_present: assert property (@(posedge clk) disable iff (!reset_n)
        (state == PHR_PSDU) |-> !buffer_empty)
        else $error("frame_ctrl_fsm: PHR_PSDU with an empty buffer");

endmodule

/* design/bit_counter.sv */
`timescale 1ns/1ps

module bit_counter import tx_frame_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    frame_timing_if.counter_mp tmg
);

    count_t count;
    count_t last_value;

    // Terminal value of the current state.
    always_comb begin
        case (tmg.state)
            SHR:      last_value = SHR_LAST;
            PHR_PSDU: last_value = BYTE_LAST;
            FCS:      last_value = FCS_LAST;
            default:  last_value = '0;
        endcase
    end

    assign tmg.count_last = (tmg.state != WAITING) && (count == last_value);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (tmg.state == WAITING || tmg.count_last) begin
            count <= '0;   // Wrap together with the state change.
        end else begin
            count <= count + count_t'(1);
        end
    end

    assign tmg.count   = count;
    assign tmg.bit_idx = count[2:0];   // LSB first within each byte.

endmodule

/* design/crc16_engine.sv */
`timescale 1ns/1ps

module crc16_engine import tx_frame_pkg::*; (
    input  logic            clk,
    input  logic            reset_n,
    frame_timing_if.data_mp tmg,
    input  byte_t           data_byte,
    output crc_t            crc
);

    logic feedback;
    crc_t crc_next;

    assign feedback = data_byte[tmg.bit_idx] ^ crc[0];

    // One step of the reflected LFSR.
    assign crc_next = (crc >> 1) ^ (feedback ? CRC_POLY_REFL : '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            crc <= CRC_INIT;
        end else begin
            case (tmg.state)
                PHR_PSDU: crc <= crc_next;
                FCS:      crc <= crc;        // Held while the FCS goes out.
                default:  crc <= CRC_INIT;
            endcase
        end
    end

endmodule

/* design/payload_buffer.sv */
`timescale 1ns/1ps

module payload_buffer import tx_frame_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              wr_en,
    input  byte_t             wr_data,
    frame_timing_if.buffer_mp tmg,
    output byte_t             head,
    output logic              empty,
    output logic              full
);

    localparam int FILL_W = $clog2(BUF_DEPTH + 1);

    byte_t              mem [BUF_DEPTH];
    buf_ptr_t           wr_ptr;
    buf_ptr_t           rd_ptr;
    logic [FILL_W-1:0]  fill;
    logic               push;

    assign push = wr_en && !full;   // Writes into a full buffer are lost.

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + buf_ptr_t'(1);   // Wraps at the depth.
            if (tmg.pop)
                rd_ptr <= rd_ptr + buf_ptr_t'(1);
            case ({push, tmg.pop})
                2'b10:   fill <= fill + FILL_W'(1);
                2'b01:   fill <= fill - FILL_W'(1);
                default: fill <= fill;
            endcase
        end
    end

    assign head          = mem[rd_ptr];
    assign empty         = (fill == '0);
    assign full          = (fill == FILL_W'(BUF_DEPTH));
    assign tmg.last_byte = (fill == FILL_W'(1));

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
        tmg.pop |-> !empty)
        else $error("payload_buffer: pop while empty");

endmodule

/* design/frame_mux.sv */
`timescale 1ns/1ps

module frame_mux import tx_frame_pkg::*; (
    frame_timing_if.data_mp tmg,
    input  byte_t           head,
    input  crc_t            crc,
    output byte_t           tx_byte
);

    always_comb begin
        case (tmg.state)
            SHR: begin
                if (tmg.count < PREAMBLE_CYCLES)
                    tx_byte = PREAMBLE_BYTE;
                else if (tmg.count < PREAMBLE_CYCLES + BYTE_LAST + count_t'(1))
                    tx_byte = SFD_BYTE0;
                else
                    tx_byte = SFD_BYTE1;
            end
            PHR_PSDU: begin
                tx_byte = head;   // Payload passes through unchanged.
            end
            FCS: begin
                // Low byte first.
                if (tmg.count <= BYTE_LAST)
                    tx_byte = crc[7:0];
                else
                    tx_byte = crc[15:8];
            end
            default: begin
                tx_byte = '0;
            end
        endcase
    end

endmodule

/* design/bit_serializer.sv */
`timescale 1ns/1ps

module bit_serializer import tx_frame_pkg::*; (
    input  logic            clk,
    input  logic            reset_n,
    frame_timing_if.data_mp tmg,
    input  byte_t           tx_byte,
    output logic            tx_bit,
    output logic            tx_valid
);

    logic active;

    assign active = (tmg.state != WAITING);

    // Serial output trails tx_byte by one cycle.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tx_bit   <= 1'b0;
            tx_valid <= 1'b0;
        end else begin
            tx_bit   <= tx_byte[tmg.bit_idx];
            tx_valid <= active;
        end
    end

endmodule

/* design/tx_frame_top.sv */
`timescale 1ns/1ps

module tx_frame_top import tx_frame_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    input  logic  wr_en,
    input  byte_t wr_data,
    input  logic  start,
    output logic  buffer_full,
    output logic  busy,
    output byte_t tx_byte,
    output logic  tx_bit,
    output logic  tx_valid,
    output logic  frame_done
);

    byte_t head;
    crc_t  crc;
    logic  buffer_empty;
    logic  host_wr;

    assign host_wr = wr_en && !busy;   // Host is locked out during a frame.

    frame_timing_if tmg ();

    frame_ctrl_fsm i_frame_ctrl_fsm (
        .clk          (clk),
        .reset_n      (reset_n),
        .start        (start),
        .tmg          (tmg.ctrl_mp),
        .buffer_empty (buffer_empty),
        .busy         (busy),
        .frame_done   (frame_done)
    );

    bit_counter i_bit_counter (
        .clk     (clk),
        .reset_n (reset_n),
        .tmg     (tmg.counter_mp)
    );

    payload_buffer i_payload_buffer (
        .clk     (clk),
        .reset_n (reset_n),
        .wr_en   (host_wr),
        .wr_data (wr_data),
        .tmg     (tmg.buffer_mp),
        .head    (head),
        .empty   (buffer_empty),
        .full    (buffer_full)
    );

    crc16_engine i_crc16_engine (
        .clk       (clk),
        .reset_n   (reset_n),
        .tmg       (tmg.data_mp),
        .data_byte (head),
        .crc       (crc)
    );

    frame_mux i_frame_mux (
        .tmg     (tmg.data_mp),
        .head    (head),
        .crc     (crc),
        .tx_byte (tx_byte)
    );

    bit_serializer i_bit_serializer (
        .clk      (clk),
        .reset_n  (reset_n),
        .tmg      (tmg.data_mp),
        .tx_byte  (tx_byte),
        .tx_bit   (tx_bit),
        .tx_valid (tx_valid)
    );

endmodule

/* tb/tb_tx_frame.sv */
`timescale 1ns/1ps

module tb_tx_frame import tx_frame_pkg::*; ();

    logic        clk = 1'b0;
    logic        reset_n;
    logic        wr_en;
    byte_t       wr_data;
    logic        start;
    logic        buffer_full;
    logic        busy;
    byte_t       tx_byte;
    logic        tx_bit;
    logic        tx_valid;
    logic        frame_done;
    logic [31:0] lcg_state = 32'd96242;

    tx_frame_top i_tx_frame_top (
        .clk         (clk),
        .reset_n     (reset_n),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .start       (start),
        .buffer_full (buffer_full),
        .busy        (busy),
        .tx_byte     (tx_byte),
        .tx_bit      (tx_bit),
        .tx_valid    (tx_valid),
        .frame_done  (frame_done)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // CCITT CRC, reflected, LSB of each byte first.
    function automatic crc_t ref_crc(input byte_t data[$]);
        crc_t c;
        c = 16'hffff;
        foreach (data[i]) begin
            for (int b = 0; b < 8; b++) begin
                if (c[0] ^ data[i][b])
                    c = (c >> 1) ^ 16'h8408;
                else
                    c = c >> 1;
            end
        end
        return c;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            stop_with_failure("Value check failed.");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic load_payload(input byte_t payload[$]);
        foreach (payload[i]) begin
            next_cycle();
            wr_en   = 1'b1;
            wr_data = payload[i];
        end
        next_cycle();
        wr_en = 1'b0;
    endtask

    task automatic pulse_start();
        next_cycle();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    // Header, payload, then FCS low byte first.
    task automatic build_expected(input byte_t payload[$], output byte_t exp[$]);
        crc_t c;
        exp = {};
        repeat (8) exp.push_back(8'haa);
        exp.push_back(8'hf3);
        exp.push_back(8'h98);
        foreach (payload[i]) exp.push_back(payload[i]);
        c = ref_crc(payload);
        exp.push_back(c[7:0]);
        exp.push_back(c[15:8]);
    endtask

    // Samples on the falling edge while tx_valid is high and rebuilds the bytes.
    task automatic collect_and_check(input byte_t exp[$]);
        byte_t got[$];
        byte_t rx_shift;
        int    bits;
        int    wait_cycles;
        int    done_count;
        int    done_index;
        wait_cycles = 0;
        bits        = 0;
        done_count  = 0;
        done_index  = -1;
        rx_shift    = '0;
        @(negedge clk);
        while (!tx_valid) begin
            wait_cycles++;
            if (wait_cycles > 20)
                stop_with_failure("tx_valid did not rise after start.");
            @(negedge clk);
        end
        while (tx_valid) begin
            rx_shift = {tx_bit, rx_shift[7:1]};
            if (frame_done) begin
                done_count++;
                done_index = bits;
            end
            // tx_byte leads the serial bit by one cycle.
            if (bits % 8 == 7 && bits / 8 + 1 < exp.size())
                check_value($sformatf("tx_byte %0d", bits / 8 + 1), 32'(tx_byte),
                            32'(exp[bits / 8 + 1]));
            bits++;
            if (bits % 8 == 0)
                got.push_back(rx_shift);
            if (bits > exp.size() * 8)
                stop_with_failure("tx_valid stayed high past the end of the frame.");
            @(negedge clk);
        end
        check_value("tx_valid cycles", bits, exp.size() * 8);
        foreach (exp[i])
            check_value($sformatf("frame byte %0d", i), 32'(got[i]), 32'(exp[i]));
        check_value("frame_done count", done_count, 1);
        check_value("frame_done position", done_index, bits - 2);
        check_value("busy", 32'(busy), 32'd0);
    endtask

    task automatic send_frame(input byte_t payload[$]);
        byte_t exp[$];
        build_expected(payload, exp);
        load_payload(payload);
        pulse_start();
        collect_and_check(exp);
    endtask

    task automatic random_payload(input int len, output byte_t payload[$]);
        payload = {};
        repeat (len) payload.push_back(byte_t'(lcg_next() >> 16));
    endtask

    task automatic test_single_byte();
        byte_t payload[$];
        payload = {8'h3c};
        send_frame(payload);
    endtask

    task automatic test_random_frames();
        byte_t payload[$];
        int    len;
        repeat (5) begin
            len = 2 + int'((lcg_next() >> 16) % 32'd39);
            random_payload(len, payload);
            send_frame(payload);
        end
    endtask

    task automatic test_ignored_starts();
        byte_t payload[$];
        byte_t exp[$];
        pulse_start();   // Buffer is empty here.
        check_value("busy", 32'(busy), 32'd0);
        next_cycle();
        check_value("busy", 32'(busy), 32'd0);
        random_payload(5, payload);
        build_expected(payload, exp);
        load_payload(payload);
        pulse_start();
        fork
            collect_and_check(exp);
            begin
                repeat (30) next_cycle();
                start   = 1'b1;
                wr_en   = 1'b1;
                wr_data = 8'h5a;   // Dropped, the frame is running.
                next_cycle();
                start = 1'b0;
                wr_en = 1'b0;
                repeat (60) next_cycle();
                pulse_start();
            end
        join
        pulse_start();
        check_value("busy", 32'(busy), 32'd0);
    endtask

    task automatic test_full_buffer();
        byte_t payload[$];
        byte_t extra[$];
        byte_t exp[$];
        random_payload(64, payload);
        build_expected(payload, exp);
        load_payload(payload);
        check_value("buffer_full", 32'(buffer_full), 32'd1);
        extra = {8'hc3};
        load_payload(extra);
        check_value("buffer_full", 32'(buffer_full), 32'd1);
        pulse_start();
        collect_and_check(exp);
        check_value("buffer_full", 32'(buffer_full), 32'd0);
    endtask

    task automatic test_reset_mid_frame();
        byte_t payload[$];
        random_payload(10, payload);
        load_payload(payload);
        pulse_start();
        repeat (120) next_cycle();
        reset_n = 1'b0;
        #1;
        check_value("busy", 32'(busy), 32'd0);
        check_value("tx_valid", 32'(tx_valid), 32'd0);
        check_value("frame_done", 32'(frame_done), 32'd0);
        check_value("tx_byte", 32'(tx_byte), 32'd0);
        repeat (4) next_cycle();
        reset_n = 1'b1;
        pulse_start();   // Buffer was cleared by the reset.
        check_value("busy", 32'(busy), 32'd0);
        random_payload(7, payload);
        send_frame(payload);
    endtask

    task automatic test_back_to_back();
        byte_t payload[$];
        random_payload(3, payload);
        send_frame(payload);
        send_frame(payload);   // Same bytes must give the same FCS again.
        random_payload(9, payload);
        send_frame(payload);
    endtask

    initial begin
        reset_n = 1'b0;
        wr_en   = 1'b0;
        wr_data = '0;
        start   = 1'b0;
        repeat (4) @(posedge clk);
        #5;
        check_value("busy", 32'(busy), 32'd0);
        check_value("tx_valid", 32'(tx_valid), 32'd0);
        check_value("frame_done", 32'(frame_done), 32'd0);
        check_value("buffer_full", 32'(buffer_full), 32'd0);
        check_value("tx_byte", 32'(tx_byte), 32'd0);
        reset_n = 1'b1;
        test_single_byte();
        test_random_frames();
        test_ignored_starts();
        test_full_buffer();
        test_reset_mid_frame();
        test_back_to_back();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* tx_frame.f */
design/tx_frame_pkg.sv
design/frame_timing_if.sv
design/frame_ctrl_fsm.sv
design/bit_counter.sv
design/crc16_engine.sv
design/payload_buffer.sv
design/frame_mux.sv
design/bit_serializer.sv
design/tx_frame_top.sv
tb/tb_tx_frame.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the framer testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f tx_frame.f \
    --top-module tb_tx_frame \
    --Mdir obj_dir

./obj_dir/Vtb_tx_frame
